// File: project.f
src/rv_decode_pkg.sv
src/bundle_skid_buffer.sv
src/bundle_dispatch.sv
src/rv_decoder.sv
src/decode_collector.sv
src/decode_stage.sv
verification/decode_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator.
# Run from the project root so the vector file path resolves.
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing -f project.f --top-module decode_stage_tb \
   -o decode_stage_sim > build.log 2>&1 \
   && ./obj_dir/decode_stage_sim > sim.log 2>&1 \
   || { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "Done: errors found" sim.log \
   && { echo "FAIL"; exit 1; } \
   || { echo "PASS"; exit 0; }

// File: verification/decode_input.hex
// in: {valid pc instr} x2 | out per lane: valid pc iclass rd rs1 rs2 funct3 f7b5 imm target
// then redirect_valid redirect_pc; one vector per line
1 1000 00c58533 1 1004 407302b3 1 1000 1 a b c 0 0 0 0 1 1004 1 5 6 7 0 1 0 0 0 0
1 2000 fff10093 1 2004 00822183 1 2000 0 1 2 0 0 0 ffffffff 0 1 2004 2 3 4 0 2 0 8 0 0 0
1 3000 fe532e23 1 3004 00208863 1 3000 3 0 6 5 2 0 fffffffc 0 1 3004 4 0 1 2 0 0 10 3014 0 0
1 4000 fe418ce3 1 4004 ff0280e7 1 4000 4 0 3 4 0 0 fffffff8 3ff8 1 4004 6 1 5 0 0 0 fffffff0 0 0 0
1 5000 800003b7 1 5004 12345417 1 5000 7 7 0 0 0 0 80000000 0 1 5004 8 8 0 0 0 0 12345000 0 0 0
1 6000 00c58533 1 6004 100000ef 1 6000 1 a b c 0 0 0 0 1 6004 5 1 0 0 0 0 100 6104 1 6104
1 7000 ffdff0ef 1 7004 407302b3 1 7000 5 1 0 0 0 0 fffffffc 6ffc 0 7004 1 5 6 7 0 1 0 0 1 6ffc
1 8000 ffffffff 1 8004 02c58533 1 8000 f 0 0 0 0 0 0 0 1 8004 f 0 0 0 0 0 0 0 0 0
0 9000 100000ef 1 9004 800003b7 0 0 f 0 0 0 0 0 0 0 1 9004 7 7 0 0 0 0 80000000 0 0 0
1 a000 fff10093 0 a004 00c58533 1 a000 0 1 2 0 0 0 ffffffff 0 0 0 f 0 0 0 0 0 0 0 0 0
1 b000 40315093 1 b004 40311093 1 b000 0 1 2 0 5 1 403 0 1 b004 f 0 0 0 0 0 0 0 0 0
1 c000 7ff00f93 1 c004 0020a863 1 c000 0 1f 0 0 0 0 7ff 0 1 c004 f 0 0 0 0 0 0 0 0 0
1 d000 100000ef 1 d004 ffdff0ef 1 d000 5 1 0 0 0 0 100 d100 0 d004 5 1 0 0 0 0 fffffffc d000 1 d100
0 e000 00c58533 0 e004 ffdff0ef 0 0 f 0 0 0 0 0 0 0 0 0 f 0 0 0 0 0 0 0 0 0
1 f000 80052483 1 f004 7ff02fa3 1 f000 2 9 a 0 2 0 fffff800 0 1 f004 3 0 0 1f 2 0 7ff 0 0 0
1 10000 fffff117 1 10004 000000e3 1 10000 8 2 0 0 0 0 fffff000 0 1 10004 4 0 0 0 0 0 800 10804 0 0

// File: verification/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb import rv_decode_pkg::*;;

   localparam int LANES = 2;
   localparam int NVEC = 16;
   // 3 words per input slot, 10 per expected lane, 2 for the redirect
   localparam int WORDS = 3 * LANES + 10 * LANES + 2;

   logic                    clk;
   logic                    rst_n;
   logic                    in_valid;
   logic                    in_ready;
   fetch_slot_t [LANES-1:0] in_bundle;
   logic                    out_valid;
   logic                    out_ready;
   decoded_t [LANES-1:0]    out_bundle;
   logic                    redirect_valid;
   logic [xlen-1:0]         redirect_pc;

   logic [31:0] vec_mem [0:NVEC*WORDS-1];
   integer      seed = 43355;
   bit          started = 1'b0;
   int          out_idx = 0;

   decode_stage #(
      .LANES (LANES)
   ) decode_stage_inst (
      .clk            (clk),
      .rst_n          (rst_n),
      .in_valid       (in_valid),
      .in_ready       (in_ready),
      .in_bundle      (in_bundle),
      .out_valid      (out_valid),
      .out_ready      (out_ready),
      .out_bundle     (out_bundle),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic compare_word(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      assert (got === exp) else begin
         $display("[ERROR] %s got %h expected %h", name, got, exp);
         $display("Done: errors found");
         $fatal(1);
      end
   endtask

   task automatic check_bundle(input int v);
      int    e;
      string p;
      e = v * WORDS + 3 * LANES;
      for (int l = 0; l < LANES; l++) begin
         p = $sformatf("vector %0d out_bundle[%0d]", v, l);
         compare_word({p, ".valid"}, {31'b0, out_bundle[l].valid}, vec_mem[e]);
         compare_word({p, ".pc"}, out_bundle[l].pc, vec_mem[e + 1]);
         compare_word({p, ".iclass"}, {28'b0, out_bundle[l].iclass}, vec_mem[e + 2]);
         compare_word({p, ".rd"}, {27'b0, out_bundle[l].rd}, vec_mem[e + 3]);
         compare_word({p, ".rs1"}, {27'b0, out_bundle[l].rs1}, vec_mem[e + 4]);
         compare_word({p, ".rs2"}, {27'b0, out_bundle[l].rs2}, vec_mem[e + 5]);
         compare_word({p, ".funct3"}, {29'b0, out_bundle[l].funct3}, vec_mem[e + 6]);
         compare_word({p, ".funct7_b5"}, {31'b0, out_bundle[l].funct7_b5}, vec_mem[e + 7]);
         compare_word({p, ".imm"}, out_bundle[l].imm, vec_mem[e + 8]);
         compare_word({p, ".target"}, out_bundle[l].target, vec_mem[e + 9]);
         e = e + 10;
      end
      p = $sformatf("vector %0d", v);
      compare_word({p, " redirect_valid"}, {31'b0, redirect_valid}, vec_mem[e]);
      compare_word({p, " redirect_pc"}, redirect_pc, vec_mem[e + 1]);
   endtask

   // Driver
   initial begin
      fetch_slot_t [LANES-1:0] next_bundle;
      int                      b;
      $readmemh("verification/decode_input.hex", vec_mem);
      rst_n     = 1'b0;
      in_valid  = 1'b0;
      in_bundle = '0;
      out_ready = 1'b0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      compare_word("in_ready before first edge after reset", {31'b0, in_ready}, 32'h0);
      @(negedge clk);
      compare_word("in_ready after reset release", {31'b0, in_ready}, 32'h1);
      // Quiet period so the idle outputs get checked
      repeat (3) @(posedge clk);
      for (int v = 0; v < NVEC; v++) begin
         if (($random(seed) & 3) == 0) begin
            in_valid <= 1'b0;
            repeat (1 + ($random(seed) & 3)) @(posedge clk);
         end
         b = v * WORDS;
         for (int l = 0; l < LANES; l++) begin
            next_bundle[l].valid = vec_mem[b + 3 * l][0];
            next_bundle[l].pc    = vec_mem[b + 3 * l + 1];
            next_bundle[l].instr = vec_mem[b + 3 * l + 2];
         end
         in_valid  <= 1'b1;
         in_bundle <= next_bundle;
         started = 1'b1;
         do @(negedge clk); while (!in_ready);
         @(posedge clk);
      end
      in_valid <= 1'b0;
   end

   // Random back-pressure
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_ready <= 1'b0;
      end else begin
         out_ready <= (($random(seed) & 3) != 0);
      end
   end

   // Monitor samples at the falling edge, where all outputs are settled
   always @(negedge clk) begin
      if (rst_n) begin
         if (!started) begin
            compare_word("out_valid before first bundle", {31'b0, out_valid}, 32'h0);
         end
         if (!out_valid) begin
            compare_word("redirect_valid while idle", {31'b0, redirect_valid}, 32'h0);
         end
         if (out_valid && out_ready) begin
            assert (out_idx < NVEC) else begin
               $display("More output bundles arrived than were sent");
               $display("Done: errors found");
               $fatal(1);
            end
            check_bundle(out_idx);
            out_idx = out_idx + 1;
         end
      end
   end

   initial begin
      wait (out_idx == NVEC);
      repeat (6) @(negedge clk);
      $display("Done: no errors");
      $finish;
   end

   initial begin
      repeat (NVEC * 20 + 16) @(posedge clk);
      $display("Timeout: outputs stopped arriving after %0d of %0d bundles", out_idx, NVEC);
      $display("Done: errors found");
      $fatal(1);
   end

endmodule

// File: src/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import rv_decode_pkg::*; #(
   parameter int LANES = 2
) (
   input  logic                    clk,
   input  logic                    rst_n,

   input  logic                    in_valid,
   output logic                    in_ready,
   input  fetch_slot_t [LANES-1:0] in_bundle,

   output logic                    out_valid,
   input  logic                    out_ready,
   output decoded_t [LANES-1:0]    out_bundle,
   output logic                    redirect_valid,
   output logic [xlen-1:0]         redirect_pc
);

   typedef fetch_slot_t [LANES-1:0] fetch_bundle_t;

   // Redirect rides in the output buffer beside the decoded slots
   typedef struct packed {
      decoded_t [LANES-1:0] bundle;
      logic                 redirect_valid;
      logic [xlen-1:0]      redirect_pc;
   } out_payload_t;

   fetch_bundle_t        buf_bundle;
   logic                 buf_valid;
   logic                 buf_ready;
   fetch_bundle_t        lane_slot;
   decoded_t [LANES-1:0] lane_result;
   decoded_t [LANES-1:0] coll_bundle;
   logic                 coll_redirect_valid;
   logic [xlen-1:0]      coll_redirect_pc;
   out_payload_t         coll_payload;
   out_payload_t         out_payload;

   bundle_skid_buffer #(
      .payload_t (fetch_bundle_t)
   ) in_buffer_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_data   (in_bundle),
      .out_valid (buf_valid),
      .out_ready (buf_ready),
      .out_data  (buf_bundle)
   );

   bundle_dispatch #(
      .LANES (LANES)
   ) dispatch_inst (
      .bundle    (buf_bundle),
      .lane_slot (lane_slot)
   );

   for (genvar g = 0; g < LANES; g++) begin : g_lane
      rv_decoder decoder_inst (
         .slot   (lane_slot[g]),
         .result (lane_result[g])
      );
   end

   decode_collector #(
      .LANES (LANES)
   ) collector_inst (
      .lane_result    (lane_result),
      .bundle         (coll_bundle),
      .redirect_valid (coll_redirect_valid),
      .redirect_pc    (coll_redirect_pc)
   );

   assign coll_payload.bundle         = coll_bundle;
   assign coll_payload.redirect_valid = coll_redirect_valid;
   assign coll_payload.redirect_pc    = coll_redirect_pc;

   bundle_skid_buffer #(
      .payload_t (out_payload_t)
   ) out_buffer_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (buf_valid),
      .in_ready  (buf_ready),
      .in_data   (coll_payload),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_data  (out_payload)
   );

   assign out_bundle     = out_payload.bundle;
   // Qualified so the redirect is low whenever no bundle is presented
   assign redirect_valid = out_valid && out_payload.redirect_valid;
   assign redirect_pc    = out_payload.redirect_pc;

endmodule

// File: src/decode_collector.sv
`timescale 1ns/1ps

module decode_collector import rv_decode_pkg::*; #(
   parameter int LANES = 2
) (
   input  decoded_t [LANES-1:0] lane_result,
   output decoded_t [LANES-1:0] bundle,
   output logic                 redirect_valid,
   output logic [xlen-1:0]      redirect_pc
);

   logic [LANES-1:0][xlen-1:0] lane_target;
   logic                       jal_seen;

   // Branch targets assume taken; beq is still predicted not taken downstream
   always_comb begin
      for (int i = 0; i < LANES; i++) begin
         if (lane_result[i].iclass == cls_branch || lane_result[i].iclass == cls_jal) begin
            lane_target[i] = lane_result[i].pc + lane_result[i].imm;
         end else begin
            lane_target[i] = '0;
         end
      end
   end

   // Lowest valid jal wins, younger slots are squashed
   always_comb begin
      jal_seen       = 1'b0;
      redirect_valid = 1'b0;
      redirect_pc    = '0;
      for (int i = 0; i < LANES; i++) begin
         bundle[i]        = lane_result[i];
         bundle[i].target = lane_target[i];
         if (jal_seen) begin
            bundle[i].valid = 1'b0;
         end else if (lane_result[i].valid && lane_result[i].iclass == cls_jal) begin
            jal_seen       = 1'b1;
            redirect_valid = 1'b1;
            redirect_pc    = lane_target[i];
         end
      end
   end

endmodule

// File: src/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder import rv_decode_pkg::*; (
   input  fetch_slot_t slot,
   output decoded_t    result
);

   logic [31:0]     instr;
   logic [6:0]      opcode;
   logic [2:0]      funct3;
   logic [6:0]      funct7;
   instr_class_e    iclass;
   logic            writes_rd;
   logic            reads_rs1;
   logic            reads_rs2;
   logic            has_funct3;
   logic            has_funct7_b5;
   logic [xlen-1:0] imm_i;
   logic [xlen-1:0] imm_s;
   logic [xlen-1:0] imm_b;
   logic [xlen-1:0] imm_u;
   logic [xlen-1:0] imm_j;

   assign instr  = slot.instr;
   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   always_comb begin
      iclass = cls_illegal;
      case (opcode)
         opc_alu_imm: begin
            case (funct3)
               // slli
               3'b001:  if (funct7 == 7'b0) iclass = cls_alu_imm;
               // srli or srai
               3'b101:  if (funct7 == 7'b0 || funct7 == funct7_alt) iclass = cls_alu_imm;
               default: iclass = cls_alu_imm;
            endcase
         end
         opc_alu_reg: begin
            if (funct7 == 7'b0) begin
               iclass = cls_alu_reg;
            end else if (funct7 == funct7_alt && (funct3 == 3'b000 || funct3 == 3'b101)) begin
               iclass = cls_alu_reg;
            end
         end
         opc_load: begin
            if (funct3 != 3'b011 && funct3 != 3'b110 && funct3 != 3'b111) begin
               iclass = cls_load;
            end
         end
         opc_store:  if (funct3 <= 3'b010) iclass = cls_store;
         opc_branch: if (funct3[2:1] != 2'b01) iclass = cls_branch;
         opc_jal:    iclass = cls_jal;
         opc_jalr:   if (funct3 == 3'b000) iclass = cls_jalr;
         opc_lui:    iclass = cls_lui;
         opc_auipc:  iclass = cls_auipc;
         default:    iclass = cls_illegal;
      endcase
      if (!slot.valid) begin
         iclass = cls_illegal;
      end
   end

   // Which fields the format carries
   always_comb begin
      writes_rd     = 1'b0;
      reads_rs1     = 1'b0;
      reads_rs2     = 1'b0;
      has_funct3    = 1'b0;
      has_funct7_b5 = 1'b0;
      case (iclass)
         cls_alu_imm: begin
            writes_rd     = 1'b1;
            reads_rs1     = 1'b1;
            has_funct3    = 1'b1;
            // Bit 30 selects srai only for shifts, otherwise it is immediate
            has_funct7_b5 = (funct3[1:0] == 2'b01);
         end
         cls_alu_reg: begin
            writes_rd     = 1'b1;
            reads_rs1     = 1'b1;
            reads_rs2     = 1'b1;
            has_funct3    = 1'b1;
            has_funct7_b5 = 1'b1;
         end
         cls_load, cls_jalr: begin
            writes_rd  = 1'b1;
            reads_rs1  = 1'b1;
            has_funct3 = 1'b1;
         end
         cls_store, cls_branch: begin
            reads_rs1  = 1'b1;
            reads_rs2  = 1'b1;
            has_funct3 = 1'b1;
         end
         cls_jal, cls_lui, cls_auipc: writes_rd = 1'b1;
         default: ;
      endcase
   end

   assign imm_i = {{20{instr[31]}}, instr[31:20]};
   assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   assign imm_u = {instr[31:12], 12'b0};
   assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

   always_comb begin
      result        = '0;
      result.valid  = slot.valid;
      result.pc     = slot.pc;
      result.iclass = iclass;
      if (writes_rd) result.rd = instr[11:7];
      if (reads_rs1) result.rs1 = instr[19:15];
      if (reads_rs2) result.rs2 = instr[24:20];
      if (has_funct3) result.funct3 = funct3;
      if (has_funct7_b5) result.funct7_b5 = instr[30];
      case (iclass)
         cls_alu_imm, cls_load, cls_jalr: result.imm = imm_i;
         cls_store:                       result.imm = imm_s;
         cls_branch:                      result.imm = imm_b;
         cls_lui, cls_auipc:              result.imm = imm_u;
         cls_jal:                         result.imm = imm_j;
         default:                         result.imm = '0;
      endcase
   end

endmodule

// File: src/bundle_dispatch.sv
`timescale 1ns/1ps

module bundle_dispatch import rv_decode_pkg::*; #(
   parameter int LANES = 2
) (
   input  fetch_slot_t [LANES-1:0] bundle,
   output fetch_slot_t [LANES-1:0] lane_slot
);

   // An empty slot reaches its decoder as all zeros, pc and instr included
   always_comb begin
      for (int i = 0; i < LANES; i++) begin
         if (bundle[i].valid) begin
            lane_slot[i] = bundle[i];
         end else begin
            lane_slot[i] = '0;
         end
      end
   end

endmodule

// File: src/bundle_skid_buffer.sv
`timescale 1ns/1ps

module bundle_skid_buffer #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst_n,

   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,

   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_data
);

   payload_t main_data;
   payload_t skid_data;
   logic     main_valid;
   logic     skid_valid;
   logic     main_valid_next;
   logic     skid_valid_next;
   logic     ready_q;
   logic     in_fire;
   logic     main_load;

   assign in_fire   = in_valid && ready_q;
   // Main register is free when empty or being drained this cycle
   assign main_load = !main_valid || out_ready;

   always_comb begin
      main_valid_next = main_valid;
      skid_valid_next = skid_valid;
      if (main_load) begin
         if (skid_valid) begin
            main_valid_next = 1'b1;
            skid_valid_next = 1'b0;
         end else begin
            main_valid_next = in_fire;
         end
      end else if (in_fire) begin
         skid_valid_next = 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         main_valid <= 1'b0;
         skid_valid <= 1'b0;
         ready_q    <= 1'b0;
      end else begin
         main_valid <= main_valid_next;
         skid_valid <= skid_valid_next;
         ready_q    <= !skid_valid_next;
      end
   end

   // Skid entry is older than anything arriving, so it moves first
   always_ff @(posedge clk) begin
      if (main_load) begin
         main_data <= skid_valid ? skid_data : in_data;
      end
      if (!main_load && in_fire) begin
         skid_data <= in_data;
      end
   end

   assign in_ready  = ready_q;
   assign out_valid = main_valid;
   assign out_data  = main_data;

endmodule

// File: src/rv_decode_pkg.sv
package rv_decode_pkg;

   parameter int xlen = 32;

   // RV32I major opcodes handled by the decoder
   parameter logic [6:0] opc_alu_imm = 7'b0010011;
   parameter logic [6:0] opc_alu_reg = 7'b0110011;
   parameter logic [6:0] opc_load    = 7'b0000011;
   parameter logic [6:0] opc_store   = 7'b0100011;
   parameter logic [6:0] opc_branch  = 7'b1100011;
   parameter logic [6:0] opc_jal     = 7'b1101111;
   parameter logic [6:0] opc_jalr    = 7'b1100111;
   parameter logic [6:0] opc_lui     = 7'b0110111;
   parameter logic [6:0] opc_auipc   = 7'b0010111;

   // funct7 value of sub and sra/srai
   parameter logic [6:0] funct7_alt  = 7'b0100000;

   typedef enum logic [3:0] {
      cls_alu_imm = 4'h0,
      cls_alu_reg = 4'h1,
      cls_load    = 4'h2,
      cls_store   = 4'h3,
      cls_branch  = 4'h4,
      cls_jal     = 4'h5,
      cls_jalr    = 4'h6,
      cls_lui     = 4'h7,
      cls_auipc   = 4'h8,
      cls_illegal = 4'hf
   } instr_class_e;

   // One fetch slot, 65 bits
   typedef struct packed {
      logic            valid;
      logic [xlen-1:0] pc;
      logic [31:0]     instr;
   } fetch_slot_t;

   // One decoded slot, 120 bits
   typedef struct packed {
      logic            valid;
      logic [xlen-1:0] pc;
      instr_class_e    iclass;
      logic [4:0]      rd;
      logic [4:0]      rs1;
      logic [4:0]      rs2;
      logic [2:0]      funct3;
      logic            funct7_b5;
      logic [xlen-1:0] imm;
      // Filled by the collector only
      logic [xlen-1:0] target;
   } decoded_t;

endpackage
